//--- common/timer_params.svh
`ifndef TIMER_PARAMS_SVH
`define TIMER_PARAMS_SVH

// Number of timer channels in the bank.
`define TIMER_NUM_CHANNELS 2

// Register byte offsets inside one channel.
`define TIMER_COUNT_REG_OFFS 32'h0
`define TIMER_RELOAD_REG_OFFS 32'h4
`define TIMER_CONTROL_REG_OFFS 32'h8
`define TIMER_EOI_REG_OFFS 32'hc

// Lowest address bit of the register select.
`define TIMER_REG_LSB 2

// Channel field in the byte address.
`define TIMER_CHAN_LSB 4
`define TIMER_CHAN_WIDTH 4

// Count and reload after reset.
`define TIMER_RESET_COUNT 32'hffff_ffff

`endif

//--- common/wb_pkg.sv
package wb_pkg;

	// Byte address.
	typedef logic [31:0] wb_addr_t;

	// Data word.
	typedef logic [31:0] wb_data_t;

	// One select bit per byte lane.
	typedef logic [3:0] wb_sel_t;

	// Classic slave handshake states.
	typedef enum logic {
		wb_idle,
		wb_respond
	} wb_state_t;

endpackage

//--- common/timer_pkg.sv
`include "timer_params.svh"

package timer_pkg;

	// Count and reload value.
	typedef logic [31:0] count_t;

	// Word register within a channel, from the byte offsets.
	typedef enum logic [1:0] {
		reg_count   = 2'(`TIMER_COUNT_REG_OFFS >> `TIMER_REG_LSB),
		reg_reload  = 2'(`TIMER_RELOAD_REG_OFFS >> `TIMER_REG_LSB),
		reg_control = 2'(`TIMER_CONTROL_REG_OFFS >> `TIMER_REG_LSB),
		reg_eoi     = 2'(`TIMER_EOI_REG_OFFS >> `TIMER_REG_LSB)
	} reg_sel_t;

	// Control register with periodic in bit 0.
	typedef struct packed {
		logic irq_enable;
		logic enable;
		logic periodic;
	} ctrl_t;

endpackage

//--- rtl/timer_bus_fsm.sv
`timescale 1ns/100ps

`include "timer_params.svh"

module timer_bus_fsm (
	input  logic clk,
	input  logic rst,

	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  wb_pkg::wb_addr_t wb_adr,
	input  wb_pkg::wb_data_t wb_dat_w,
	input  wb_pkg::wb_sel_t wb_sel,
	output logic wb_ack,
	output logic wb_err,
	output wb_pkg::wb_data_t wb_dat_r,

	input  wb_pkg::wb_data_t [`TIMER_NUM_CHANNELS-1:0] chan_rd_data,
	output timer_pkg::reg_sel_t reg_sel,
	output wb_pkg::wb_data_t wr_data,
	output logic [`TIMER_NUM_CHANNELS-1:0] wr_en
);

	localparam int chan_idx_w = (`TIMER_NUM_CHANNELS > 1) ?
		$clog2(`TIMER_NUM_CHANNELS) : 1;

	wb_pkg::wb_state_t state;
	wb_pkg::wb_state_t state_next;

	logic [`TIMER_CHAN_WIDTH-1:0] chan;
	logic [chan_idx_w-1:0] chan_idx;
	logic chan_valid;
	logic request;

	assign request = wb_cyc && wb_stb && (state == wb_pkg::wb_idle);

	// Address split into channel and register fields.
	assign chan = wb_adr[`TIMER_CHAN_LSB +: `TIMER_CHAN_WIDTH];
	assign chan_idx = chan[chan_idx_w-1:0];
	assign chan_valid = chan < `TIMER_NUM_CHANNELS;

	assign reg_sel = timer_pkg::reg_sel_t'(wb_adr[`TIMER_REG_LSB +: 2]);

	// Byte selects are not decoded. Every write is a full word.
	assign wr_data = wb_dat_w;

	// One write strobe, for an addressed channel that exists.
	always_comb begin
		wr_en = '0;
		if (request && wb_we && chan_valid) begin
			wr_en[chan_idx] = 1'b1;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			wb_pkg::wb_idle: begin
				if (request) begin
					state_next = wb_pkg::wb_respond;
				end
			end
			wb_pkg::wb_respond: begin
				// Back to idle so a slow stb drop is not answered twice.
				state_next = wb_pkg::wb_idle;
			end
			default: begin
				state_next = wb_pkg::wb_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= wb_pkg::wb_idle;
		end else begin
			state <= state_next;
		end
	end

	// Response lasts the single respond cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
		end else begin
			wb_ack <= request && chan_valid;
			wb_err <= request && !chan_valid;
		end
	end

	// Read word captured at the answering edge.
	always_ff @(posedge clk) begin
		if (request) begin
			if (chan_valid) begin
				wb_dat_r <= chan_rd_data[chan_idx];
			end else begin
				wb_dat_r <= '0;
			end
		end
	end

endmodule

//--- timer/timer_counter.sv
`timescale 1ns/100ps

`include "timer_params.svh"

module timer_counter (
	input  logic clk,
	input  logic rst,

	input  logic load,
	input  timer_pkg::count_t load_value,
	input  logic enable,
	input  logic periodic,

	output timer_pkg::count_t count,
	output logic at_zero
);

	logic periodic_reload;
	logic decrement;

	assign at_zero = (count == '0);

	// Periodic mode replaces zero with the reload value.
	assign periodic_reload = enable && periodic && at_zero;

	// One-shot mode parks at zero.
	assign decrement = enable && !at_zero;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= `TIMER_RESET_COUNT;
		end else if (load) begin
			count <= load_value;
		end else if (periodic_reload) begin
			count <= load_value;
		end else if (decrement) begin
			count <= count - timer_pkg::count_t'(1);
		end
	end

endmodule

//--- timer/timer_channel_regs.sv
`timescale 1ns/100ps

`include "timer_params.svh"

module timer_channel_regs (
	input  logic clk,
	input  logic rst,

	input  logic wr_en,
	input  timer_pkg::reg_sel_t reg_sel,
	input  wb_pkg::wb_data_t wr_data,
	output wb_pkg::wb_data_t rd_data,

	input  timer_pkg::count_t count,
	input  logic at_zero,
	output logic load,
	output timer_pkg::count_t load_value,
	output logic enable,
	output logic periodic,

	output logic irq
);

	timer_pkg::count_t reload_val;
	timer_pkg::ctrl_t ctrl;
	logic pending;
	logic acked;

	logic write_reload;
	logic write_control;
	logic write_eoi;
	logic periodic_reload;
	logic raise;

	assign write_reload = wr_en && (reg_sel == timer_pkg::reg_reload);
	assign write_control = wr_en && (reg_sel == timer_pkg::reg_control);
	assign write_eoi = wr_en && (reg_sel == timer_pkg::reg_eoi);

	// A reload write also loads the count at the same edge.
	assign load = write_reload;
	assign load_value = write_reload ? timer_pkg::count_t'(wr_data) : reload_val;

	assign enable = ctrl.enable;
	assign periodic = ctrl.periodic;

	// Same condition the counter uses for its periodic reload.
	assign periodic_reload = ctrl.enable && ctrl.periodic && at_zero;

	// A fresh zero after a periodic reload is not blocked by an old EOI.
	assign raise = at_zero && ctrl.irq_enable && (!acked || periodic_reload);

	assign irq = pending && ctrl.irq_enable;

	always_ff @(posedge clk) begin
		if (rst) begin
			reload_val <= `TIMER_RESET_COUNT;
			ctrl <= '0;
		end else begin
			if (write_reload) begin
				reload_val <= timer_pkg::count_t'(wr_data);
			end
			if (write_control) begin
				ctrl <= timer_pkg::ctrl_t'(wr_data[$bits(timer_pkg::ctrl_t)-1:0]);
			end
		end
	end

	// EOI wins over a zero seen at the same edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			acked <= 1'b0;
		end else if (write_eoi) begin
			pending <= 1'b0;
			acked <= 1'b1;
		end else begin
			if (load || periodic_reload) begin
				acked <= 1'b0;
			end
			if (raise) begin
				pending <= 1'b1;
			end
		end
	end

	always_comb begin
		rd_data = '0;
		case (reg_sel)
			timer_pkg::reg_count: begin
				rd_data = wb_pkg::wb_data_t'(count);
			end
			timer_pkg::reg_reload: begin
				rd_data = wb_pkg::wb_data_t'(reload_val);
			end
			timer_pkg::reg_control: begin
				rd_data[$bits(timer_pkg::ctrl_t)-1:0] = ctrl;
			end
			default: begin
				// EOI is write only.
				rd_data = '0;
			end
		endcase
	end

endmodule

//--- rtl/timer_bank_top.sv
`timescale 1ns/100ps

`include "timer_params.svh"

module timer_bank_top (
	input  logic clk,
	input  logic rst,

	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  wb_pkg::wb_addr_t wb_adr,
	input  wb_pkg::wb_data_t wb_dat_w,
	input  wb_pkg::wb_sel_t wb_sel,
	output logic wb_ack,
	output logic wb_err,
	output wb_pkg::wb_data_t wb_dat_r,

	output logic [`TIMER_NUM_CHANNELS-1:0] irq_vec,
	output logic irq
);

	wb_pkg::wb_data_t [`TIMER_NUM_CHANNELS-1:0] chan_rd_data;
	logic [`TIMER_NUM_CHANNELS-1:0] wr_en;
	timer_pkg::reg_sel_t reg_sel;
	wb_pkg::wb_data_t wr_data;

	timer_bus_fsm timer_bus_fsm_inst (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_ack(wb_ack),
		.wb_err(wb_err),
		.wb_dat_r(wb_dat_r),
		.chan_rd_data(chan_rd_data),
		.reg_sel(reg_sel),
		.wr_data(wr_data),
		.wr_en(wr_en)
	);

	for (genvar gi = 0; gi < `TIMER_NUM_CHANNELS; gi++) begin : gen_chan
		timer_pkg::count_t count;
		timer_pkg::count_t load_value;
		logic at_zero;
		logic load;
		logic enable;
		logic periodic;

		timer_channel_regs timer_channel_regs_inst (
			.clk(clk),
			.rst(rst),
			.wr_en(wr_en[gi]),
			.reg_sel(reg_sel),
			.wr_data(wr_data),
			.rd_data(chan_rd_data[gi]),
			.count(count),
			.at_zero(at_zero),
			.load(load),
			.load_value(load_value),
			.enable(enable),
			.periodic(periodic),
			.irq(irq_vec[gi])
		);

		timer_counter timer_counter_inst (
			.clk(clk),
			.rst(rst),
			.load(load),
			.load_value(load_value),
			.enable(enable),
			.periodic(periodic),
			.count(count),
			.at_zero(at_zero)
		);
	end

	// Any channel interrupting.
	assign irq = |irq_vec;

endmodule

//--- test/timer_tb_clock.sv
`timescale 1ns/100ps

module timer_tb_clock #(
	parameter int half_period_ns = 10
) (
	output logic clk
);

	// Free running, 20 ns period.
	initial begin
		clk = 1'b0;
		forever begin
			#(half_period_ns) clk = ~clk;
		end
	end

endmodule

//--- test/timer_tb.sv
`timescale 1ns/100ps

`include "timer_params.svh"

module timer_tb;

	localparam int clk_period_ns = 20;
	localparam int reset_cycles = 4;
	localparam int num_tests = 6;
	localparam int test_budget_cycles = 200;
	localparam int margin_cycles = 100;
	localparam int watchdog_ns =
		(reset_cycles + num_tests * test_budget_cycles + margin_cycles) * clk_period_ns;
	localparam int bus_timeout = 16;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_pkg::wb_addr_t wb_adr;
	wb_pkg::wb_data_t wb_dat_w;
	wb_pkg::wb_sel_t wb_sel;
	logic wb_ack;
	logic wb_err;
	wb_pkg::wb_data_t wb_dat_r;
	logic [`TIMER_NUM_CHANNELS-1:0] irq_vec;
	logic irq;

	logic [31:0] lcg_state = 32'h2c09_253e;
	int errors = 0;
	int test_errors_at_start = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	// Pending read comparisons.
	wb_pkg::wb_data_t exp_q[$];
	wb_pkg::wb_data_t got_q[$];
	string name_q[$];

	// Model of what was written to each channel.
	timer_pkg::count_t count_m[`TIMER_NUM_CHANNELS];
	timer_pkg::count_t reload_m[`TIMER_NUM_CHANNELS];
	wb_pkg::wb_data_t ctrl_m[`TIMER_NUM_CHANNELS];

	timer_tb_clock timer_tb_clock_inst (
		.clk(clk)
	);

	timer_bank_top timer_bank_top_inst (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_ack(wb_ack),
		.wb_err(wb_err),
		.wb_dat_r(wb_dat_r),
		.irq_vec(irq_vec),
		.irq(irq)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic wb_pkg::wb_addr_t reg_addr(input int chan, input wb_pkg::wb_addr_t offs);
		return (wb_pkg::wb_addr_t'(chan) << `TIMER_CHAN_LSB) | offs;
	endfunction

	// Control keeps bits 2:0 and EOI reads as zero.
	function automatic wb_pkg::wb_data_t expected_read(input timer_pkg::reg_sel_t sel,
		input timer_pkg::count_t count_v, input timer_pkg::count_t reload_v,
		input wb_pkg::wb_data_t ctrl_v);
		case (sel)
			timer_pkg::reg_count: return count_v;
			timer_pkg::reg_reload: return reload_v;
			timer_pkg::reg_control: return {29'b0, ctrl_v[2:0]};
			default: return '0;
		endcase
	endfunction

	task automatic check_data(input string name, input wb_pkg::wb_data_t exp,
		input wb_pkg::wb_data_t got);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	// Compares each finished read against its expected word.
	always begin
		wait (got_q.size() > 0);
		check_data(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
	end

	task automatic bus_cycle(input wb_pkg::wb_addr_t addr, input logic we,
		input wb_pkg::wb_data_t data, output wb_pkg::wb_data_t rdata, output logic err);
		int waited;
		logic [31:0] sel_rand;
		waited = 0;
		sel_rand = lcg_next();
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = addr;
		wb_dat_w = data;
		wb_sel = sel_rand[3:0];
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && !wb_err && waited < bus_timeout);
		if (!wb_ack && !wb_err) begin
			$display("No ack or err from the DUT for address %h within %0d cycles",
				addr, bus_timeout);
			errors++;
		end
		if (wb_ack && wb_err) begin
			$display("DUT raised ack and err together for address %h", addr);
			errors++;
		end
		rdata = wb_dat_r;
		err = wb_err;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input wb_pkg::wb_addr_t addr, input wb_pkg::wb_data_t data);
		wb_pkg::wb_data_t unused;
		logic err;
		bus_cycle(addr, 1'b1, data, unused, err);
		check_bit("wb_err", 1'b0, err);
	endtask

	task automatic wb_read(input wb_pkg::wb_addr_t addr, output wb_pkg::wb_data_t data);
		logic err;
		bus_cycle(addr, 1'b0, '0, data, err);
		check_bit("wb_err", 1'b0, err);
	endtask

	task automatic read_expect(input wb_pkg::wb_addr_t addr, input wb_pkg::wb_data_t exp,
		input string name);
		wb_pkg::wb_data_t got;
		wb_read(addr, got);
		name_q.push_back(name);
		exp_q.push_back(exp);
		got_q.push_back(got);
	endtask

	task automatic begin_test();
		test_errors_at_start = errors;
	endtask

	task automatic end_test(input string label);
		wait (got_q.size() == 0);
		if (errors == test_errors_at_start) begin
			$display("Test %s: ok", label);
			tests_ok++;
		end else begin
			$display("Test %s: %0d error(s)", label, errors - test_errors_at_start);
			tests_bad++;
		end
	endtask

	initial begin
		#(watchdog_ns);
		$display("Run timed out after %0d ns", watchdog_ns);
		$display("test failed");
		$finish;
	end

	initial begin
		int c;
		int i;
		int n;
		logic err;
		logic seen_high;
		logic rose;
		wb_pkg::wb_data_t got;
		wb_pkg::wb_data_t junk;

		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Register readback on both channels.
		begin_test();
		for (c = 0; c < `TIMER_NUM_CHANNELS; c++) begin
			reload_m[c] = lcg_next();
			ctrl_m[c] = lcg_next() & ~32'h2;
			count_m[c] = reload_m[c];
			wb_write(reg_addr(c, `TIMER_RELOAD_REG_OFFS), reload_m[c]);
			wb_write(reg_addr(c, `TIMER_CONTROL_REG_OFFS), ctrl_m[c]);
		end
		for (c = 0; c < `TIMER_NUM_CHANNELS; c++) begin
			wb_write(reg_addr(c, `TIMER_COUNT_REG_OFFS), lcg_next());
			read_expect(reg_addr(c, `TIMER_RELOAD_REG_OFFS), expected_read(
				timer_pkg::reg_reload, count_m[c], reload_m[c], ctrl_m[c]), "reload");
			read_expect(reg_addr(c, `TIMER_CONTROL_REG_OFFS), expected_read(
				timer_pkg::reg_control, count_m[c], reload_m[c], ctrl_m[c]), "control");
			read_expect(reg_addr(c, `TIMER_EOI_REG_OFFS), expected_read(
				timer_pkg::reg_eoi, count_m[c], reload_m[c], ctrl_m[c]), "eoi");
			read_expect(reg_addr(c, `TIMER_COUNT_REG_OFFS), expected_read(
				timer_pkg::reg_count, count_m[c], reload_m[c], ctrl_m[c]), "count");
		end
		end_test("1 readback");

		// One-shot on channel 0 with channel 1 quiet.
		begin_test();
		n = 3 + (lcg_next() % 8);
		ctrl_m[1] = '0;
		wb_write(reg_addr(1, `TIMER_CONTROL_REG_OFFS), ctrl_m[1]);
		wb_write(reg_addr(0, `TIMER_CONTROL_REG_OFFS), 32'h0);
		reload_m[0] = n;
		wb_write(reg_addr(0, `TIMER_RELOAD_REG_OFFS), reload_m[0]);
		ctrl_m[0] = 32'h6;
		wb_write(reg_addr(0, `TIMER_CONTROL_REG_OFFS), ctrl_m[0]);
		repeat (n + 3) @(negedge clk);
		read_expect(reg_addr(0, `TIMER_COUNT_REG_OFFS), expected_read(
			timer_pkg::reg_count, 32'h0, reload_m[0], ctrl_m[0]), "count");
		check_bit("irq_vec[0]", 1'b1, irq_vec[0]);
		check_bit("irq_vec[1]", 1'b0, irq_vec[1]);
		check_bit("irq", 1'b1, irq);
		end_test("2 one-shot");

		// EOI keeps the line low while count stays at zero.
		begin_test();
		wb_write(reg_addr(0, `TIMER_EOI_REG_OFFS), 32'h0);
		seen_high = irq_vec[0] | irq;
		for (i = 0; i < 40; i++) begin
			@(negedge clk);
			seen_high = seen_high | irq_vec[0] | irq;
		end
		check_bit("irq_vec[0]", 1'b0, seen_high);
		read_expect(reg_addr(0, `TIMER_COUNT_REG_OFFS), 32'h0, "count");
		end_test("3 eoi");

		// Periodic restarts from the reload value.
		begin_test();
		ctrl_m[0] = 32'h7;
		wb_write(reg_addr(0, `TIMER_CONTROL_REG_OFFS), ctrl_m[0]);
		wb_write(reg_addr(0, `TIMER_EOI_REG_OFFS), 32'h0);
		rose = 1'b0;
		for (i = 0; i < n + 3 && !rose; i++) begin
			@(negedge clk);
			rose = irq_vec[0];
		end
		if (!rose) begin
			$display("Channel 0 interrupt did not rise again within %0d cycles", n + 3);
			errors++;
		end
		for (i = 0; i < 8; i++) begin
			wb_read(reg_addr(0, `TIMER_COUNT_REG_OFFS), got);
			if (got > n) begin
				$display("Mismatch at %0t ns: count expected 0 to %0d, got %0d", $time, n, got);
				errors++;
			end
		end
		end_test("4 periodic");

		// Channel fields past the last channel answer with err.
		begin_test();
		for (i = 0; i < 4; i++) begin
			c = 2 + (lcg_next() % 14);
			bus_cycle(reg_addr(c, `TIMER_RELOAD_REG_OFFS), 1'b1, lcg_next(), junk, err);
			check_bit("wb_err", 1'b1, err);
			bus_cycle(reg_addr(c, `TIMER_CONTROL_REG_OFFS), 1'b1, lcg_next(), junk, err);
			check_bit("wb_err", 1'b1, err);
			bus_cycle(reg_addr(c, `TIMER_RELOAD_REG_OFFS), 1'b0, '0, junk, err);
			check_bit("wb_err", 1'b1, err);
		end
		for (c = 0; c < `TIMER_NUM_CHANNELS; c++) begin
			read_expect(reg_addr(c, `TIMER_RELOAD_REG_OFFS), expected_read(
				timer_pkg::reg_reload, count_m[c], reload_m[c], ctrl_m[c]), "reload");
			read_expect(reg_addr(c, `TIMER_CONTROL_REG_OFFS), expected_read(
				timer_pkg::reg_control, count_m[c], reload_m[c], ctrl_m[c]), "control");
		end
		end_test("5 bad channel");

		// IRQ enable masks the pending flag.
		begin_test();
		ctrl_m[0] = 32'h6;
		wb_write(reg_addr(0, `TIMER_CONTROL_REG_OFFS), ctrl_m[0]);
		repeat (n + 3) @(negedge clk);
		check_bit("irq_vec[0]", 1'b1, irq_vec[0]);
		ctrl_m[0] = 32'h2;
		wb_write(reg_addr(0, `TIMER_CONTROL_REG_OFFS), ctrl_m[0]);
		check_bit("irq_vec[0]", 1'b0, irq_vec[0]);
		check_bit("irq", 1'b0, irq);
		ctrl_m[0] = 32'h6;
		wb_write(reg_addr(0, `TIMER_CONTROL_REG_OFFS), ctrl_m[0]);
		check_bit("irq_vec[0]", 1'b1, irq_vec[0]);
		check_bit("irq", 1'b1, irq);
		end_test("6 irq mask");

		$display("Tests ok: %0d, tests with errors: %0d, check errors: %0d",
			tests_ok, tests_bad, errors);
		if (tests_bad == 0 && errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+common
common/wb_pkg.sv
common/timer_pkg.sv
rtl/timer_bus_fsm.sv
timer/timer_counter.sv
timer/timer_channel_regs.sv
rtl/timer_bank_top.sv
test/timer_tb_clock.sv
test/timer_tb.sv
